//--- spiPkg.sv
package spiPkg;

	typedef logic [7:0] byteT;
	typedef logic [5:0] ioAddrT;
	typedef logic [5:0] halfCntT;		// Divider count

	//********************
	// Register layouts
	//********************

	// SPCR, top bit down
	typedef struct packed {
		logic			spie;		// Interrupt enable
		logic			spe;		// Port enable
		logic			dord;		// LSB first when set
		logic			mstr;		// Always reads 1
		logic			cpol;		// Idle level of sck
		logic			cpha;
		logic [1:0]		spr;		// Rate select
	} spcrT;

	// SPSR
	typedef struct packed {
		logic			spif;		// Transfer complete
		logic			wcol;		// Write collision
		logic [4:0]		rsvd;		// Read as 0
		logic			spi2x;		// Double speed
	} spsrT;

	//********************
	// Host bus
	//********************

	typedef struct packed {
		ioAddrT			addr;
		logic			rd;
		logic			wr;
		byteT			wdata;
	} ioBusT;

	//********************
	// Engine links
	//********************

	// Settings captured when a transfer starts
	typedef struct packed {
		logic			cpol;
		logic			cpha;
		logic			dord;
		logic [1:0]		spr;
		logic			spi2x;
	} xferCfgT;

	typedef struct packed {
		logic			start;		// One cycle strobe
		xferCfgT		cfg;
		byteT			data;		// Byte to send
	} xferCmdT;

	typedef struct packed {
		logic			done;		// One cycle strobe
		byteT			data;		// Received byte, in register order
	} xferDoneT;

	// Half period of sck in cp2 cycles, indexed by spr
	localparam int unsigned HALF_NORMAL [4] = '{2, 8, 32, 64};
	localparam int unsigned HALF_DOUBLE [4] = '{1, 4, 16, 32};

endpackage

//--- spiClkDiv.sv
`timescale 1ns/10ps

module spiClkDiv (
	input  logic				cp2,
	input  logic				ireset,
	input  logic				run_i,
	input  spiPkg::xferCfgT		cfg_i,
	output logic				tick_o
);
	import spiPkg::*;

	halfCntT		cnt;
	halfCntT		lastCnt;
	int unsigned	halfLen;

	// Half period from the rate tables
	always_comb begin
		if (cfg_i.spi2x) begin
			halfLen = HALF_DOUBLE[cfg_i.spr];
		end else begin
			halfLen = HALF_NORMAL[cfg_i.spr];
		end
	end

	assign lastCnt = halfCntT'(halfLen - 1);

	// One pulse per half period
	assign tick_o = run_i && (cnt == lastCnt);

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			cnt <= '0;
		end else if (!run_i || tick_o) begin
			cnt <= '0;		// Restart
		end else begin
			cnt <= cnt + 6'd1;
		end
	end

endmodule

//--- spiShifter.sv
`timescale 1ns/10ps

module spiShifter (
	input  logic				cp2,
	input  logic				ireset,
	input  spiPkg::xferCmdT		cmd_i,
	input  logic				idleCpol_i,
	input  logic				cpolWr_i,
	input  logic				miso_i,
	output logic				busy_o,
	output spiPkg::xferDoneT	done_o,
	output logic				mosi_o,
	output logic				sck_o
);
	import spiPkg::*;

	typedef enum logic {
		stIdle,
		stShift
	} stateT;

	stateT		state;
	xferCfgT	cfgQ;			// Frozen for the whole transfer
	logic [3:0]	edgeCnt;		// Ticks seen so far
	byteT		shReg;
	logic		sckQ;
	logic		mosiQ;
	logic		doneQ;
	byteT		doneDataQ;

	logic		tick;
	logic		sampleNow;
	logic		shiftNow;
	logic		lastTick;
	byteT		rxByte;

	function automatic byteT revByte(input byteT b);
		byteT r;
		for (int i = 0; i < 8; i++) begin
			r[i] = b[7 - i];
		end
		return r;
	endfunction

	spiClkDiv spiClkDiv_inst (
		.cp2	(cp2),
		.ireset	(ireset),
		.run_i	(busy_o),
		.cfg_i	(cfgQ),
		.tick_o	(tick)
	);

	// Odd ticks lead, even ticks trail
	assign sampleNow = tick && (edgeCnt[0] == cfgQ.cpha);
	assign shiftNow = tick && (edgeCnt[0] != cfgQ.cpha) && (edgeCnt != 4'd15);
	assign lastTick = tick && (edgeCnt == 4'd15);

	// Last bit may arrive on the final tick
	assign rxByte = sampleNow ? {shReg[6:0], miso_i} : shReg;

	//********************
	// Transfer FSM
	//********************

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			state <= stIdle;
			edgeCnt <= '0;
			sckQ <= 1'b0;
			mosiQ <= 1'b1;
			doneQ <= 1'b0;
		end else begin
			doneQ <= lastTick;
			case (state)
				stIdle: begin
					if (cmd_i.start) begin
						state <= stShift;
						edgeCnt <= '0;
						sckQ <= cmd_i.cfg.cpol;
						mosiQ <= cmd_i.cfg.dord ? cmd_i.data[0] : cmd_i.data[7];	// First bit out now
					end else if (cpolWr_i) begin
						sckQ <= idleCpol_i;		// Follow SPCR while idle
					end
				end
				stShift: begin
					if (tick) begin
						edgeCnt <= edgeCnt + 4'd1;
						sckQ <= ~sckQ;
					end
					if (shiftNow) begin
						mosiQ <= shReg[7];
					end
					if (lastTick) begin
						state <= stIdle;		// sck is back at cpol
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	//********************
	// Shift register
	//********************

	always_ff @(posedge cp2) begin
		if (state == stIdle && cmd_i.start) begin
			cfgQ <= cmd_i.cfg;
			shReg <= cmd_i.cfg.dord ? revByte(cmd_i.data) : cmd_i.data;
		end else if (sampleNow) begin
			shReg <= {shReg[6:0], miso_i};		// Capture miso
		end
		if (lastTick) begin
			doneDataQ <= cfgQ.dord ? revByte(rxByte) : rxByte;
		end
	end

	assign busy_o = (state == stShift);
	assign done_o = '{done: doneQ, data: doneDataQ};
	assign mosi_o = mosiQ;
	assign sck_o = sckQ;

endmodule

//--- spiRegs.sv
`timescale 1ns/10ps

module spiRegs #(
	parameter spiPkg::ioAddrT spcrAddr = 6'h2C,
	parameter spiPkg::ioAddrT spsrAddr = 6'h2D,
	parameter spiPkg::ioAddrT spdrAddr = 6'h2E
) (
	input  logic				cp2,
	input  logic				ireset,
	input  spiPkg::ioBusT		bus_i,
	input  logic				busy_i,
	input  spiPkg::xferDoneT	done_i,
	output spiPkg::xferCmdT		cmd_o,
	output logic				idleCpol_o,
	output logic				cpolWr_o,
	output spiPkg::byteT		rdata_o,
	output logic				outEn_o,
	output logic				irq_o
);
	import spiPkg::*;

	spcrT	spcrQ;
	logic	spi2xQ;
	logic	spifQ;
	logic	wcolQ;
	logic	spifArmQ;		// Status was read with spif set
	logic	wcolArmQ;		// Status was read with wcol set
	byteT	rxQ;			// Receive register

	spcrT	wrSpcr;
	spsrT	wrSpsr;
	spsrT	spsrView;

	logic	spcrHit;
	logic	spsrHit;
	logic	spdrHit;
	logic	dataWr;
	logic	dataAcc;
	logic	statusRd;
	logic	collision;

	//********************
	// Address decode
	//********************

	assign spcrHit = (bus_i.addr == spcrAddr);
	assign spsrHit = (bus_i.addr == spsrAddr);
	assign spdrHit = (bus_i.addr == spdrAddr);

	assign dataWr = spdrHit && bus_i.wr;
	assign dataAcc = spdrHit && (bus_i.rd || bus_i.wr);		// Read or write of SPDR
	assign statusRd = spsrHit && bus_i.rd;
	assign collision = dataWr && busy_i;		// Byte is dropped

	assign wrSpcr = spcrT'(bus_i.wdata);
	assign wrSpsr = spsrT'(bus_i.wdata);

	// Start command to the shift engine
	assign cmd_o.start = dataWr && spcrQ.spe && !busy_i;
	assign cmd_o.cfg.cpol = spcrQ.cpol;
	assign cmd_o.cfg.cpha = spcrQ.cpha;
	assign cmd_o.cfg.dord = spcrQ.dord;
	assign cmd_o.cfg.spr = spcrQ.spr;
	assign cmd_o.cfg.spi2x = spi2xQ;
	assign cmd_o.data = bus_i.wdata;

	// New idle level for sck on a control write
	assign cpolWr_o = spcrHit && bus_i.wr;
	assign idleCpol_o = wrSpcr.cpol;

	//********************
	// Control registers
	//********************

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			spcrQ <= '0;
			spcrQ.mstr <= 1'b1;		// Master only
			spi2xQ <= 1'b0;
		end else begin
			if (cpolWr_o) begin
				spcrQ <= wrSpcr;
				spcrQ.mstr <= 1'b1;
			end
			if (spsrHit && bus_i.wr) begin
				spi2xQ <= wrSpsr.spi2x;		// Only writable SPSR bit
			end
		end
	end

	//********************
	// Status flags
	//********************

	// Flag set by an event, cleared by status read then data access
	always_ff @(posedge cp2) begin
		if (!ireset) begin
			spifQ <= 1'b0;
			wcolQ <= 1'b0;
			spifArmQ <= 1'b0;
			wcolArmQ <= 1'b0;
			rxQ <= '0;
		end else begin
			if (done_i.done) begin
				spifQ <= 1'b1;
			end else if (spifArmQ && dataAcc) begin
				spifQ <= 1'b0;
			end

			if (dataAcc) begin
				spifArmQ <= 1'b0;
			end else if (statusRd && spifQ) begin
				spifArmQ <= 1'b1;
			end

			if (collision) begin
				wcolQ <= 1'b1;
			end else if (wcolArmQ && dataAcc) begin
				wcolQ <= 1'b0;
			end

			if (dataAcc) begin
				wcolArmQ <= 1'b0;
			end else if (statusRd && wcolQ) begin
				wcolArmQ <= 1'b1;
			end

			if (done_i.done) begin
				rxQ <= done_i.data;
			end
		end
	end

	assign irq_o = spcrQ.spie && spifQ;

	//********************
	// Read mux
	//********************

	assign spsrView = '{spif: spifQ, wcol: wcolQ, rsvd: 5'b0, spi2x: spi2xQ};

	always_comb begin
		rdata_o = '0;
		outEn_o = 1'b0;
		case (bus_i.addr)
			spcrAddr: begin
				rdata_o = spcrQ;
				outEn_o = bus_i.rd;
			end
			spsrAddr: begin
				rdata_o = spsrView;
				outEn_o = bus_i.rd;
			end
			spdrAddr: begin
				rdata_o = rxQ;
				outEn_o = bus_i.rd;
			end
			default: begin
				rdata_o = '0;		// Not ours
				outEn_o = 1'b0;
			end
		endcase
	end

endmodule

//--- spiMaster.sv
`timescale 1ns/10ps

module spiMaster #(
	parameter spiPkg::ioAddrT spcrAddr = 6'h2C,
	parameter spiPkg::ioAddrT spsrAddr = 6'h2D,
	parameter spiPkg::ioAddrT spdrAddr = 6'h2E
) (
	input  logic			cp2,
	input  logic			ireset,
	input  spiPkg::ioBusT	bus_i,
	output spiPkg::byteT	rdata_o,
	output logic			outEn_o,
	output logic			irq_o,
	input  logic			miso_i,
	output logic			mosi_o,
	output logic			sck_o
);
	import spiPkg::*;

	xferCmdT	cmd;
	xferDoneT	done;
	logic		busy;
	logic		idleCpol;
	logic		cpolWr;

	// Host side registers
	spiRegs #(
		.spcrAddr	(spcrAddr),
		.spsrAddr	(spsrAddr),
		.spdrAddr	(spdrAddr)
	) spiRegs_inst (
		.cp2		(cp2),
		.ireset		(ireset),
		.bus_i		(bus_i),
		.busy_i		(busy),
		.done_i		(done),
		.cmd_o		(cmd),
		.idleCpol_o	(idleCpol),
		.cpolWr_o	(cpolWr),
		.rdata_o	(rdata_o),
		.outEn_o	(outEn_o),
		.irq_o		(irq_o)
	);

	// Serial side
	spiShifter spiShifter_inst (
		.cp2		(cp2),
		.ireset		(ireset),
		.cmd_i		(cmd),
		.idleCpol_i	(idleCpol),
		.cpolWr_i	(cpolWr),
		.miso_i		(miso_i),
		.busy_o		(busy),
		.done_o		(done),
		.mosi_o		(mosi_o),
		.sck_o		(sck_o)
	);

endmodule

//--- tbSpiMaster.sv
`timescale 1ns/10ps

module tbSpiMaster;
	import spiPkg::*;

	localparam ioAddrT SPCR_A = 6'h2C;
	localparam ioAddrT SPSR_A = 6'h2D;
	localparam ioAddrT SPDR_A = 6'h2E;
	localparam int WATCHDOG_CYCLES = 200 * (16 * 64 + 50) + 2000;

	logic	cp2;
	logic	ireset;
	ioBusT	bus;
	byteT	rdata;
	logic	outEn;
	logic	irq;
	logic	miso;
	logic	mosi;
	logic	sck;

	int		errCnt;
	int		passCnt;
	int		testErr0;		// Error count when the current test began
	int		cycCnt;			// Rising edges of cp2
	int		startCyc;

	// Slave model state
	logic	slvActive;
	logic	prevSck;
	logic	cfgCpol;
	logic	cfgCpha;
	logic	cfgDord;
	logic	cfgDbl;
	logic	cfgSpie;
	int		expHalf;
	int		slvEdges;
	int		slvBits;
	int		lastEdgeCyc;
	byteT	misoByte;
	byteT	mosiRx;

	spiMaster #(
		.spcrAddr	(SPCR_A),
		.spsrAddr	(SPSR_A),
		.spdrAddr	(SPDR_A)
	) spiMaster_inst (
		.cp2		(cp2),
		.ireset		(ireset),
		.bus_i		(bus),
		.rdata_o	(rdata),
		.outEn_o	(outEn),
		.irq_o		(irq),
		.miso_i		(miso),
		.mosi_o		(mosi),
		.sck_o		(sck)
	);

	always #5 cp2 = ~cp2;

	always @(posedge cp2) begin
		cycCnt <= cycCnt + 1;
	end

	//********************
	// Compare tasks
	//********************

	task automatic checkByte(input string name, input byteT got, input byteT exp);
		if (got !== exp) begin
			errCnt++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end else begin
			passCnt++;
		end
	endtask

	task automatic checkSpsr(input string name, input spsrT got, input spsrT exp);
		if (got !== exp) begin
			errCnt++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end else begin
			passCnt++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errCnt++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end else begin
			passCnt++;
		end
	endtask

	task automatic checkCount(input string name, input int unsigned got, input int unsigned exp);
		if (got !== exp) begin
			errCnt++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end else begin
			passCnt++;
		end
	endtask

	task automatic endTest(input string name);
		int n;
		n = errCnt - testErr0;
		if (n == 0) begin
			$display("Test %s: pass", name);
		end else begin
			$display("Test %s: fail, %0d errors", name, n);
		end
		testErr0 = errCnt;
	endtask

	// Half period of sck in cp2 cycles
	function automatic int halfPeriod(input logic [1:0] spr, input logic dbl);
		int norm;
		case (spr)
			2'd0: norm = 2;
			2'd1: norm = 8;
			2'd2: norm = 32;
			default: norm = 64;
		endcase
		return dbl ? norm / 2 : norm;
	endfunction

	// Register bit for the k-th bit on the wire
	function automatic int bitPos(input int k, input logic dord);
		return dord ? k : 7 - k;
	endfunction

	//********************
	// Slave model
	//********************

	always @(negedge cp2) begin
		if (slvActive && sck !== prevSck) begin
			if (slvEdges > 0) begin
				checkCount("sck_o half period", cycCnt - lastEdgeCyc, expHalf);
			end
			lastEdgeCyc = cycCnt;
			slvEdges++;
			if (sck == (cfgCpol == cfgCpha) && slvBits < 8) begin		// Sampling edge
				mosiRx[bitPos(slvBits, cfgDord)] = mosi;
				slvBits++;
				if (slvBits < 8) begin
					miso = misoByte[bitPos(slvBits, cfgDord)];
				end
			end
		end
		prevSck = sck;
	end

	//********************
	// Host bus tasks
	//********************

	task automatic busWrite(input ioAddrT a, input byteT d);
		@(negedge cp2);
		bus = '{addr: a, rd: 1'b0, wr: 1'b1, wdata: d};
		@(negedge cp2);
		bus = '0;
	endtask

	task automatic busRead(input ioAddrT a, output byteT d, output logic en);
		@(negedge cp2);
		bus = '{addr: a, rd: 1'b1, wr: 1'b0, wdata: 8'h00};
		#1;
		d = rdata;
		en = outEn;
		@(negedge cp2);
		bus = '0;
	endtask

	task automatic setupXfer(input logic cpol, cpha, dord, input logic [1:0] spr,
			input logic dbl, input logic spie, input logic spe);
		spcrT c;
		c = '{spie: spie, spe: spe, dord: dord, mstr: 1'b0, cpol: cpol, cpha: cpha, spr: spr};
		busWrite(SPSR_A, {7'b0, dbl});
		busWrite(SPCR_A, c);
		@(negedge cp2);
		checkBit("sck_o idle", sck, cpol);
		cfgCpol = cpol;
		cfgCpha = cpha;
		cfgDord = dord;
		cfgDbl = dbl;
		cfgSpie = spie;
		expHalf = halfPeriod(spr, dbl);
		misoByte = $urandom;
		mosiRx = '0;
		slvEdges = 0;
		slvBits = 0;
		miso = misoByte[bitPos(0, dord)];		// First bit ready before start
		slvActive = 1'b1;
	endtask

	task automatic startXfer(input byteT tx);
		busWrite(SPDR_A, tx);
		startCyc = cycCnt - 1;
	endtask

	// Poll status until spif, bounded by the transfer length
	task automatic waitSpif(output spsrT st);
		byteT d;
		logic en;
		int lim;
		lim = 16 * expHalf + 3;
		st = '0;
		while (!st.spif && (cycCnt - startCyc) <= lim + 1) begin
			busRead(SPSR_A, d, en);
			st = spsrT'(d);
		end
		if (!st.spif) begin
			errCnt++;
			$display("SPIF did not set within %0d cycles of the data write", lim);
		end else if (cycCnt - 1 - startCyc > lim) begin
			errCnt++;
			$display("SPIF set %0d cycles after the data write, limit is %0d",
				cycCnt - 1 - startCyc, lim);
		end
	endtask

	task automatic finishXfer(input spsrT st, input byteT tx, input logic expWcol);
		spsrT exp;
		byteT d;
		logic en;
		exp = '{spif: 1'b1, wcol: expWcol, rsvd: 5'b0, spi2x: cfgDbl};
		checkSpsr("SPSR at done", st, exp);
		checkBit("irq_o", irq, cfgSpie);
		busRead(SPDR_A, d, en);		// Status was read, so this clears
		checkByte("SPDR", d, misoByte);
		checkByte("mosi_o byte", mosiRx, tx);
		checkCount("sck_o edges", slvEdges, 16);
		checkBit("sck_o idle", sck, cfgCpol);
		checkBit("irq_o cleared", irq, 1'b0);
		busRead(SPSR_A, d, en);
		exp.spif = 1'b0;
		exp.wcol = 1'b0;
		checkSpsr("SPSR cleared", spsrT'(d), exp);
		slvActive = 1'b0;
	endtask

	// r holds cpol, cpha, dord, spr, spi2x, spie from bit 0 up
	task automatic runXfer(input logic [7:0] r);
		byteT tx;
		spsrT st;
		setupXfer(r[0], r[1], r[2], r[4:3], r[5], r[6], 1'b1);
		tx = $urandom;
		startXfer(tx);
		waitSpif(st);
		finishXfer(st, tx, 1'b0);
	endtask

	//********************
	// Stimulus
	//********************

	initial begin
		spsrT st;
		byteT d;
		byteT w;
		byteT tx;
		logic en;
		ioAddrT a;
		logic [7:0] r;
		int n;
		void'($urandom(80));
		cp2 = 1'b0;
		ireset = 1'b0;
		bus = '0;
		miso = 1'b1;
		errCnt = 0;
		passCnt = 0;
		testErr0 = 0;
		cycCnt = 0;
		startCyc = 0;
		slvActive = 1'b0;
		prevSck = 1'b0;
		{cfgCpol, cfgCpha, cfgDord, cfgDbl, cfgSpie} = '0;
		expHalf = 2;
		repeat (16) @(negedge cp2);
		ireset = 1'b1;

		// Reset values and register access
		checkBit("sck_o after reset", sck, 1'b0);
		checkBit("mosi_o after reset", mosi, 1'b1);
		checkBit("irq_o after reset", irq, 1'b0);
		busRead(SPCR_A, d, en);
		checkByte("SPCR after reset", d, 8'h10);
		checkBit("outEn_o", en, 1'b1);
		busRead(SPSR_A, d, en);
		checkSpsr("SPSR after reset", spsrT'(d), '0);
		busRead(SPDR_A, d, en);
		checkByte("SPDR after reset", d, 8'h00);
		repeat (20) begin
			w = $urandom;
			busWrite(SPCR_A, w);
			busRead(SPCR_A, d, en);
			checkByte("SPCR", d, w | 8'h10);		// mstr stuck at 1
			w = $urandom;
			busWrite(SPSR_A, w);
			busRead(SPSR_A, d, en);
			checkSpsr("SPSR", spsrT'(d),
				spsrT'{spif: 1'b0, wcol: 1'b0, rsvd: 5'b0, spi2x: w[0]});
			do begin
				a = ioAddrT'($urandom);
			end while (a >= SPCR_A && a <= SPDR_A);
			busRead(a, d, en);
			checkBit("outEn_o", en, 1'b0);
		end
		endTest("register access");

		// Every mode and rate once, then random settings
		for (int i = 0; i < 88; i++) begin
			if (i < 64) begin
				r = i[7:0];
			end else begin
				r = $urandom;
			end
			r[6] = $urandom % 2;
			runXfer(r);
		end
		endTest("random transfers");

		for (int k = 0; k < 8; k++) begin
			r = $urandom;
			r[4:3] = k[1:0];
			r[5] = k[2];
			runXfer(r);
		end
		endTest("rate");

		// Flag and interrupt clear sequence
		r = $urandom;
		setupXfer(r[0], r[1], r[2], 2'd0, 1'b0, 1'b1, 1'b1);
		tx = $urandom;
		startXfer(tx);
		n = 0;
		while (!irq && n <= 16 * expHalf + 3) begin
			@(negedge cp2);
			n++;
		end
		if (!irq) begin
			errCnt++;
			$display("irq_o did not rise after the transfer");
		end
		busRead(SPDR_A, d, en);
		checkByte("SPDR", d, misoByte);
		checkBit("irq_o after SPDR read alone", irq, 1'b1);
		busRead(SPSR_A, d, en);
		checkSpsr("SPSR after SPDR read alone", spsrT'(d),
			spsrT'{spif: 1'b1, wcol: 1'b0, rsvd: 5'b0, spi2x: 1'b0});
		busRead(SPDR_A, d, en);
		checkBit("irq_o after SPSR then SPDR", irq, 1'b0);
		busRead(SPSR_A, d, en);
		checkSpsr("SPSR after SPSR then SPDR", spsrT'(d), '0);
		checkByte("mosi_o byte", mosiRx, tx);
		slvActive = 1'b0;
		endTest("flag and interrupt");

		// Second data write lands while busy
		r = $urandom;
		setupXfer(r[0], r[1], r[2], 2'd1, 1'b0, r[6], 1'b1);
		tx = $urandom;
		startXfer(tx);
		busWrite(SPDR_A, ~tx);
		waitSpif(st);
		finishXfer(st, tx, 1'b1);
		endTest("write collision");

		// Port disabled
		r = $urandom;
		setupXfer(r[0], r[1], r[2], 2'd3, 1'b0, 1'b0, 1'b0);
		busWrite(SPDR_A, $urandom);
		repeat (16 * 64 + 20) @(negedge cp2);
		checkCount("sck_o edges", slvEdges, 0);
		busRead(SPSR_A, d, en);
		checkSpsr("SPSR", spsrT'(d), '0);
		slvActive = 1'b0;
		endTest("disabled port");

		$display("Checks passed: %0d, errors: %0d", passCnt, errCnt);
		if (errCnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge cp2);
		$display("Timeout: the run did not complete in %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- build.f
spiPkg.sv
spiClkDiv.sv
spiShifter.sv
spiRegs.sv
spiMaster.sv
tbSpiMaster.sv
